// File: design/heapPkg.sv
// Heap memory sizes
// Command and error enumerations
// Request, response and array descriptor structs

package heapPkg;

  // ----------------------------------------
  // Sizes
  localparam int ARRAY_BITS   = 2;                  // Bits of an array number
  localparam int ARRAY_COUNT  = 1 << ARRAY_BITS;    // Arrays in the heap
  localparam int INDEX_BITS   = 2;                  // Bits of an element index
  localparam int ARRAY_LENGTH = 1 << INDEX_BITS;    // Maximum elements per array
  localparam int DATA_BITS    = 16;                 // Element width

  // ----------------------------------------
  // Enumerations
  typedef enum logic [2:0] {
    opRead, opWrite, opSize, opPush, opPop, opAdd, opAlloc, opFree
  } heapOpT;

  typedef enum logic [2:0] {
    errNone,
    errNotIssued,                                   // Array number never handed out
    errFreed,                                       // Array released by free
    errOutOfBounds,                                 // Index at or past the size
    errFull,
    errEmpty,
    errOutOfMemory
  } heapErrorT;

  // ----------------------------------------
  // Structs
  typedef struct packed {
    logic                  allocated;               // Set by alloc, cleared by free
    logic [INDEX_BITS:0]   size;                    // Elements in use, 0 to ARRAY_LENGTH
  } arrayInfoT;

  typedef struct packed {
    heapOpT                op;
    logic [ARRAY_BITS-1:0] array;
    logic [INDEX_BITS-1:0] index;
    logic [DATA_BITS-1:0]  data;
  } heapRequestT;

  typedef struct packed {
    logic [DATA_BITS-1:0]  data;
    heapErrorT             error;
  } heapResponseT;

endpackage

// File: design/arrayStore.sv
// Single-port synchronous storage
// One write port and one registered read, read before write

`timescale 1ns/1ps

module arrayStore #(
  parameter type entryT = logic [7:0],              // Payload of one entry
  parameter int  DEPTH  = 4
) (
  input  logic                     clock,
  input  logic                     enable,
  input  logic                     write,
  input  logic [$clog2(DEPTH)-1:0] address,
  input  entryT                    writeData,
  output entryT                    readData
);

  entryT memory [DEPTH];                            // Storage array

  // Old contents come out on a write to the same address
  always_ff @(posedge clock) begin
    if (enable) begin
      readData <= memory[address];                  // Valid the cycle after enable
      if (write) begin
        memory[address] <= writeData;
      end
    end
  end

endmodule

// File: design/arrayAllocator.sv
// Array number allocator
// Counter of arrays issued since reset and stack of freed array numbers

`timescale 1ns/1ps

module arrayAllocator (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          allocTake,
  input  logic                          freePush,
  input  logic [heapPkg::ARRAY_BITS-1:0] freeArray,
  output logic [heapPkg::ARRAY_BITS-1:0] nextArray,
  output logic                          allocAvailable,
  output logic [heapPkg::ARRAY_BITS:0]   issuedCount
);

  import heapPkg::*;

  logic [ARRAY_BITS-1:0] freedStack [ARRAY_COUNT];  // Freed array numbers
  logic [ARRAY_BITS:0]   freedTop;                  // Entries on the stack
  logic [ARRAY_BITS:0]   topBelow;                  // Slot of the last freed number
  logic                  stackEmpty;

  assign stackEmpty = freedTop == '0;
  assign topBelow   = freedTop - 1'b1;

  // Last freed first, then never-issued numbers in order
  assign nextArray = stackEmpty ? issuedCount[ARRAY_BITS-1:0]
                                : freedStack[topBelow[ARRAY_BITS-1:0]];

  assign allocAvailable = !stackEmpty ||
                          issuedCount != (ARRAY_BITS + 1)'(ARRAY_COUNT);

  // ----------------------------------------
  // Counters
  always_ff @(posedge clock) begin
    if (reset) begin
      issuedCount <= '0;
      freedTop    <= '0;
    end else if (allocTake) begin
      if (stackEmpty) begin
        issuedCount <= issuedCount + 1'b1;           // Hand out a new number
      end else begin
        freedTop <= topBelow;                        // Reuse a freed number
      end
    end else if (freePush) begin
      freedTop <= freedTop + 1'b1;
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (freePush) begin
      freedStack[freedTop[ARRAY_BITS-1:0]] <= freeArray;
    end
  end

endmodule

// File: design/heapController.sv
// Heap command state machine
// Access checks, result computation and store and allocator control
// One command in flight, descriptor read before element address is known

`timescale 1ns/1ps

module heapController (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic                                            reqValid,
  output logic                                            reqReady,
  input  heapPkg::heapRequestT                            request,
  output logic                                            respValid,
  input  logic                                            respReady,
  output heapPkg::heapResponseT                           response,
  output logic                                            descEnable,
  output logic                                            descWrite,
  output logic [heapPkg::ARRAY_BITS-1:0]                  descAddress,
  output heapPkg::arrayInfoT                              descWriteData,
  input  heapPkg::arrayInfoT                              descReadData,
  output logic                                            elemEnable,
  output logic                                            elemWrite,
  output logic [heapPkg::ARRAY_BITS+heapPkg::INDEX_BITS-1:0] elemAddress,
  output logic [heapPkg::DATA_BITS-1:0]                   elemWriteData,
  input  logic [heapPkg::DATA_BITS-1:0]                   elemReadData,
  output logic                                            allocTake,
  output logic                                            freePush,
  output logic [heapPkg::ARRAY_BITS-1:0]                  freeArray,
  input  logic [heapPkg::ARRAY_BITS-1:0]                  nextArray,
  input  logic                                            allocAvailable,
  input  logic [heapPkg::ARRAY_BITS:0]                    issuedCount
);

  import heapPkg::*;

  typedef enum logic [2:0] {
    idleState, descriptorState, elementState, executeState, respondState
  } stateT;

  stateT                 state;
  heapRequestT           req;                       // Accepted command
  heapErrorT             checkError;
  arrayInfoT             newInfo;                   // Descriptor after the command
  logic [INDEX_BITS:0]   slot;                      // Element touched by the command
  logic [DATA_BITS-1:0]  sum;
  logic [DATA_BITS-1:0]  resultData;
  logic                  descUpdate;
  logic                  elemUpdate;
  logic                  executing;

  assign executing = state == executeState;
  assign reqReady  = state == idleState;
  assign respValid = state == respondState;

  // ----------------------------------------
  // Sequence and registers
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idleState;
    end else begin
      case (state)
        idleState:       if (reqValid) state <= descriptorState;
        descriptorState: state <= elementState;
        elementState:    state <= executeState;
        executeState:    state <= respondState;
        respondState:    if (respReady) state <= idleState;
        default:         state <= idleState;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reqReady && reqValid) req <= request;
    if (executing) response <= '{data: resultData, error: checkError};
  end

  // ----------------------------------------
  // Access checks, valid in EXECUTE
  always_comb begin
    checkError = errNone;
    if (req.op == opAlloc) begin
      if (!allocAvailable) checkError = errOutOfMemory;
    end else if ({1'b0, req.array} >= issuedCount) begin
      checkError = errNotIssued;
    end else if (!descReadData.allocated) begin
      checkError = errFreed;
    end else if ((req.op == opRead || req.op == opAdd) &&
                 {1'b0, req.index} >= descReadData.size) begin
      checkError = errOutOfBounds;
    end else if (req.op == opPush &&
                 descReadData.size == (INDEX_BITS + 1)'(ARRAY_LENGTH)) begin
      checkError = errFull;
    end else if (req.op == opPop && descReadData.size == '0) begin
      checkError = errEmpty;
    end
  end

  // Pop reads the last element, push writes just past it
  always_comb begin
    case (req.op)
      opPop:   slot = descReadData.size - 1'b1;
      opPush:  slot = descReadData.size;
      default: slot = {1'b0, req.index};
    endcase
  end

  assign sum = elemReadData + req.data;             // Wraps at DATA_BITS

  // ----------------------------------------
  // Results and store updates
  always_comb begin
    newInfo    = descReadData;
    resultData = '0;
    descUpdate = 1'b0;
    elemUpdate = 1'b0;
    case (req.op)
      opRead: resultData = elemReadData;
      opWrite: begin
        if (slot >= descReadData.size) newInfo.size = slot + 1'b1;  // Extend past the end
        descUpdate = 1'b1;
        elemUpdate = 1'b1;
        resultData = req.data;
      end
      opSize: resultData = DATA_BITS'(descReadData.size);
      opPush: begin
        newInfo.size = descReadData.size + 1'b1;
        descUpdate   = 1'b1;
        elemUpdate   = 1'b1;
        resultData   = req.data;
      end
      opPop: begin
        newInfo.size = slot;
        descUpdate   = 1'b1;
        resultData   = elemReadData;
      end
      opAdd: begin
        elemUpdate = 1'b1;
        resultData = sum;
      end
      opAlloc: begin
        newInfo    = '{allocated: 1'b1, size: '0};  // Fresh empty array
        descUpdate = 1'b1;
        resultData = DATA_BITS'(nextArray);
      end
      opFree: begin
        newInfo.allocated = 1'b0;
        descUpdate        = 1'b1;
      end
      default: resultData = '0;
    endcase
    if (checkError != errNone) begin                // Errors leave state alone
      descUpdate = 1'b0;
      elemUpdate = 1'b0;
      resultData = '0;
    end
  end

  // ----------------------------------------
  // Store and allocator drive
  assign descEnable    = state == descriptorState || (executing && descUpdate);
  assign descWrite     = executing && descUpdate;
  assign descAddress   = (executing && req.op == opAlloc) ? nextArray : req.array;
  assign descWriteData = newInfo;

  assign elemEnable    = state == elementState || (executing && elemUpdate);
  assign elemWrite     = executing && elemUpdate;
  assign elemAddress   = {req.array, slot[INDEX_BITS-1:0]};
  assign elemWriteData = req.op == opAdd ? sum : req.data;

  assign allocTake = executing && req.op == opAlloc && checkError == errNone;
  assign freePush  = executing && req.op == opFree && checkError == errNone;
  assign freeArray = req.array;

endmodule

// File: design/heapMemory.sv
// Heap memory top level
// Controller, allocator, descriptor store and element store

`timescale 1ns/1ps

module heapMemory (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  reqValid,
  output logic                  reqReady,
  input  heapPkg::heapRequestT  request,
  output logic                  respValid,
  input  logic                  respReady,
  output heapPkg::heapResponseT response
);

  import heapPkg::*;

  // ----------------------------------------
  // Internal links
  logic                             descEnable, descWrite;
  logic [ARRAY_BITS-1:0]            descAddress;
  arrayInfoT                        descWriteData, descReadData;
  logic                             elemEnable, elemWrite;
  logic [ARRAY_BITS+INDEX_BITS-1:0] elemAddress;
  logic [DATA_BITS-1:0]             elemWriteData, elemReadData;
  logic                             allocTake, freePush, allocAvailable;
  logic [ARRAY_BITS-1:0]            freeArray, nextArray;
  logic [ARRAY_BITS:0]              issuedCount;

  heapController u_heapController (
    .clock, .reset, .reqValid, .reqReady, .request,
    .respValid, .respReady, .response,
    .descEnable, .descWrite, .descAddress, .descWriteData, .descReadData,
    .elemEnable, .elemWrite, .elemAddress, .elemWriteData, .elemReadData,
    .allocTake, .freePush, .freeArray, .nextArray, .allocAvailable, .issuedCount
  );

  arrayAllocator u_arrayAllocator (
    .clock, .reset, .allocTake, .freePush, .freeArray,
    .nextArray, .allocAvailable, .issuedCount
  );

  arrayStore #(.entryT(arrayInfoT), .DEPTH(ARRAY_COUNT)) descriptorStore (  // One per array
    .clock, .enable(descEnable), .write(descWrite), .address(descAddress),
    .writeData(descWriteData), .readData(descReadData)
  );

  arrayStore #(
    .entryT(logic [DATA_BITS-1:0]),
    .DEPTH (ARRAY_COUNT * ARRAY_LENGTH)             // Fixed block per array
  ) elementStore (
    .clock, .enable(elemEnable), .write(elemWrite), .address(elemAddress),
    .writeData(elemWriteData), .readData(elemReadData)
  );

endmodule

// File: verif/heapMemory_props.sv
// Handshake and timing assertions for the heap memory top level
// Attached to heapMemory with bind

`timescale 1ns/1ps

module heapMemory_props (
  input logic                  clock,
  input logic                  reset,
  input logic                  reqValid,
  input logic                  reqReady,
  input logic                  respValid,
  input logic                  respReady,
  input heapPkg::heapResponseT response
);

  int   failures = 0;                               // Read by the testbench top
  logic accepted;
  logic taken;

  assign accepted = reqValid && reqReady;
  assign taken    = respValid && respReady;

  assert property (@(posedge clock) reset |=> reqReady && !respValid)
    else begin failures++; $error("DUT not idle after reset"); end

  // Four cycles from acceptance to respValid, busy meanwhile
  assert property (@(posedge clock) disable iff (reset)
    accepted |=> (!respValid && !reqReady) ##1 (!respValid && !reqReady)
                 ##1 (!respValid && !reqReady) ##1 respValid)
    else begin failures++; $error("respValid not exactly four cycles after accept"); end

  assert property (@(posedge clock) disable iff (reset)
    respValid && !respReady |=> respValid && $stable(response))
    else begin failures++; $error("response dropped or changed under back-pressure"); end

  assert property (@(posedge clock) disable iff (reset) respValid |-> !reqReady)
    else begin failures++; $error("reqReady high while a response is pending"); end

  assert property (@(posedge clock) disable iff (reset) taken |=> reqReady && !respValid)
    else begin failures++; $error("DUT not idle after the response was taken"); end

endmodule

bind heapMemory heapMemory_props u_heapMemoryProps (
  .clock, .reset, .reqValid, .reqReady, .respValid, .respReady, .response
);

// File: verif/heapChecker.sv
// Heap memory response checker
// Reference model over shadow state, expected queue and comparison

`timescale 1ns/1ps

module heapChecker (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  reqValid,
  input  logic                  reqReady,
  input  heapPkg::heapRequestT  request,
  input  logic                  respValid,
  input  logic                  respReady,
  input  heapPkg::heapResponseT response,
  output int                    errorCount,
  output int                    checkCount
);

  import heapPkg::*;

  logic [DATA_BITS-1:0] elements [ARRAY_COUNT][ARRAY_LENGTH];
  bit                   known [ARRAY_COUNT][ARRAY_LENGTH];   // Element ever written
  bit                   allocated [ARRAY_COUNT];
  int                   sizes [ARRAY_COUNT];
  int                   issued;                              // Arrays handed out since reset
  int                   freedStack [$];                      // Last freed at the back
  heapResponseT         expectQ [$];
  bit                   knownQ [$];
  heapResponseT         expected;
  bit                   keepData;                            // Set by the reference model
  bit                   compareData;

  // Expected response of one command, updates the shadow state
  function automatic heapResponseT referenceModel(heapRequestT r);
    int           a;
    int           i;
    int           n;
    heapResponseT e;
    a        = r.array;
    i        = r.index;
    e        = '{data: '0, error: errNone};
    keepData = 1'b1;
    if (r.op == opAlloc) begin
      if (freedStack.size() > 0) begin
        n = freedStack.pop_back();
      end else if (issued < ARRAY_COUNT) begin
        n = issued;
        issued++;
      end else begin
        e.error = errOutOfMemory;
        return e;
      end
      allocated[n] = 1'b1;
      sizes[n]     = 0;
      e.data       = DATA_BITS'(n);
      return e;
    end
    if (a >= issued) e.error = errNotIssued;
    else if (!allocated[a]) e.error = errFreed;
    else if ((r.op == opRead || r.op == opAdd) && i >= sizes[a]) e.error = errOutOfBounds;
    else if (r.op == opPush && sizes[a] == ARRAY_LENGTH) e.error = errFull;
    else if (r.op == opPop && sizes[a] == 0) e.error = errEmpty;
    if (e.error != errNone) return e;
    case (r.op)
      opWrite: begin
        elements[a][i] = r.data;
        known[a][i]    = 1'b1;
        if (i >= sizes[a]) sizes[a] = i + 1;                // Grows past the end
        e.data = r.data;
      end
      opRead: begin
        e.data   = elements[a][i];
        keepData = known[a][i];
      end
      opSize: e.data = DATA_BITS'(sizes[a]);
      opPush: begin
        elements[a][sizes[a]] = r.data;
        known[a][sizes[a]]    = 1'b1;
        sizes[a]++;
        e.data = r.data;
      end
      opPop: begin
        sizes[a]--;
        e.data   = elements[a][sizes[a]];
        keepData = known[a][sizes[a]];
      end
      opAdd: begin
        elements[a][i] = elements[a][i] + r.data;           // Wraps at 16 bits
        e.data         = elements[a][i];
        keepData       = known[a][i];
      end
      opFree: begin
        allocated[a] = 1'b0;
        freedStack.push_back(a);
      end
      default: e.data = '0;
    endcase
    return e;
  endfunction

  // ----------------------------------------
  // Compare taken responses, queue expected ones at acceptance
  always @(posedge clock) begin
    if (reset) begin
      issued     = 0;
      errorCount = 0;
      checkCount = 0;
      freedStack.delete();
      expectQ.delete();
      knownQ.delete();
      for (int k = 0; k < ARRAY_COUNT; k++) allocated[k] = 1'b0;
    end else begin
      if (respValid && respReady) begin
        if (expectQ.size() == 0) begin
          errorCount++;
          $display("response taken at %0t with no command outstanding", $time);
        end else begin
          expected    = expectQ.pop_front();
          compareData = knownQ.pop_front();
          checkCount++;
          if (response.error !== expected.error ||
              (compareData && response.data !== expected.data)) begin
            errorCount++;
            $display("mismatch at %0t: got data %h error %0d, expected data %h error %0d",
                     $time, response.data, response.error, expected.data, expected.error);
          end
        end
      end
      if (reqValid && reqReady) begin
        expectQ.push_back(referenceModel(request));
        knownQ.push_back(keepData);
      end
    end
  end

endmodule

// File: verif/heapTb.sv
// Heap memory testbench top
// Clock, reset, LFSR, directed and random commands, back-pressure, final report

`timescale 1ns/1ps

module heapTb;

  import heapPkg::*;

  localparam int TIMEOUT_CYCLES  = 40;
  localparam int RANDOM_COMMANDS = 400;

  logic         clock;
  logic         reset;
  logic         reqValid;
  logic         reqReady;
  heapRequestT  request;
  logic         respValid;
  logic         respReady;
  heapResponseT response;
  logic [16:0]  lfsrState;
  logic         pressure;                           // Random respReady when set
  int           errorCount;
  int           checkCount;
  int           commandCount;
  int           timeoutCount;
  int           assertFailures;

  heapMemory u_heapMemory (.*);

  heapChecker u_heapChecker (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;                        // 100 ns period

  // ----------------------------------------
  // Fibonacci LFSR with taps for x^17 + x^14 + 1
  function automatic logic takeBit();
    logic feedback;
    feedback  = lfsrState[16] ^ lfsrState[13];
    lfsrState = {lfsrState[15:0], feedback};
    return feedback;
  endfunction

  function automatic logic [15:0] randomBits(int width);
    logic [15:0] value;
    value = '0;
    for (int k = 0; k < width; k++) begin
      value = {value[14:0], takeBit()};
    end
    return value;
  endfunction

  // Step one edge and change inputs 1 ns later
  task automatic nextCycle();
    @(posedge clock);
    #1;
    respReady = pressure ? takeBit() : 1'b1;
  endtask

  // Send one command and wait until its response is taken
  task automatic issue(heapOpT op, int array = 0, int index = 0, int data = 0);
    int waited;
    waited = 0;
    if (timeoutCount > 0) return;
    request = '{op: op, array: array[ARRAY_BITS-1:0], index: index[INDEX_BITS-1:0],
                data: data[DATA_BITS-1:0]};
    reqValid = 1'b1;
    while (!reqReady && waited < TIMEOUT_CYCLES) begin
      nextCycle();
      waited++;
    end
    if (!reqReady) begin
      $display("timeout at %0t: the DUT never raised reqReady", $time);
      timeoutCount++;
      reqValid = 1'b0;
      return;
    end
    nextCycle();                                    // Accepted at this edge
    reqValid = 1'b0;
    commandCount++;
    waited = 0;
    while (!(respValid && respReady) && waited < TIMEOUT_CYCLES) begin
      nextCycle();
      waited++;
    end
    if (!(respValid && respReady)) begin
      $display("timeout at %0t: no response was taken", $time);
      timeoutCount++;
      return;
    end
    nextCycle();                                    // Response taken at this edge
  endtask

  initial begin
    logic [15:0] bits;
    heapRequestT pick;
    reset        = 1'b1;
    reqValid     = 1'b0;
    respReady    = 1'b1;
    request      = '0;
    pressure     = 1'b0;
    lfsrState    = 17'd88307;
    commandCount = 0;
    timeoutCount = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // ----------------------------------------
    // Directed commands
    issue(opRead, 2);                               // Never issued
    repeat (5) issue(opAlloc);                      // 0 to 3 then out of memory
    issue(opFree, 2);
    issue(opFree, 1);
    issue(opAlloc);
    issue(opAlloc);
    issue(opFree, 3);                               // Fresh array 3
    issue(opAlloc);
    issue(opWrite, 3, 2, 16'hbeef);
    issue(opSize, 3);
    issue(opRead, 3, 2);
    issue(opRead, 3, 3);
    for (int k = 0; k < 5; k++) issue(opPush, 0, 0, 16'h1000 + k);
    repeat (5) issue(opPop, 0);
    issue(opWrite, 1, 0, 16'hfff0);
    issue(opAdd, 1, 0, 16'h0025);                   // Wraps to 0x0015
    issue(opRead, 1, 0);
    issue(opFree, 2);
    issue(opRead, 2, 0);
    issue(opFree, 2);
    issue(opPush, 2, 0, 7);
    issue(opAlloc);                                 // Gets 2 back once only
    issue(opAlloc);

    // ----------------------------------------
    // Random commands under back-pressure
    pressure = 1'b1;
    for (int n = 0; n < RANDOM_COMMANDS; n++) begin
      bits       = randomBits(3);
      pick.op    = heapOpT'(bits[2:0]);
      bits       = randomBits(ARRAY_BITS);
      pick.array = bits[ARRAY_BITS-1:0];
      bits       = randomBits(INDEX_BITS);
      pick.index = bits[INDEX_BITS-1:0];
      pick.data  = randomBits(DATA_BITS);
      issue(pick.op, int'(pick.array), int'(pick.index), int'(pick.data));
    end

    assertFailures = u_heapMemory.u_heapMemoryProps.failures;
    $display("commands %0d, checked %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             commandCount, checkCount, errorCount, timeoutCount, assertFailures);
    if (errorCount == 0 && timeoutCount == 0 && assertFailures == 0 &&
        checkCount == commandCount && checkCount > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: heapMemory.f
design/heapPkg.sv
design/arrayStore.sv
design/arrayAllocator.sv
design/heapController.sv
design/heapMemory.sv
verif/heapMemory_props.sv
verif/heapChecker.sv
verif/heapTb.sv

// File: Makefile
TOP = heapTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f heapMemory.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f heapMemory.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
